// ==== include/hh_defs.svh ====
`ifndef HH_DEFS_SVH
`define HH_DEFS_SVH

// sizing of the header writer

// number of header_synthesis lanes working side by side, 2, 4 or 8 all work
`define HH_LANES 4

// width of a character index coming from the codebook walker
`define HH_CHAR_W 8

// leading 1 plus the character bits that open every fragment
`define HH_LEAD_BITS 9

// a fragment adds at most two trailing zeros after the lead bits
`define HH_MAX_ZEROS 2

`endif

// ==== hdl/hh_pkg.sv ====
`include "hh_defs.svh"

package hh_pkg;

    // leaf view of a tree element, top bit low means a character
    typedef struct packed {
        logic                  is_sum;     // low for a leaf
        logic [`HH_CHAR_W-1:0] char_index; // character carried by the leaf
    } htree_leaf_t;

    // sum view of the same element, top bit high means an inner node
    typedef struct packed {
        logic                  is_sum;     // high for a sum node
        logic [`HH_CHAR_W-1:0] node_index; // index of the sum node in the tree
    } htree_sum_t;

    // one 9-bit tree element, read through whichever view is_sum selects
    typedef union packed {
        htree_leaf_t leaf; // view used when is_sum is low
        htree_sum_t  sum;  // view used when is_sum is high
    } htree_elem_u;

    // number of trailing zeros after the lead bits, 0 to 2
    typedef logic [1:0] zero_cnt_t;

    // pointer into the lane array, shared by the dispatcher and the collector
    typedef logic [$clog2(`HH_LANES)-1:0] lane_idx_t;

endpackage

// ==== hdl/header_req_if.sv ====
`include "hh_defs.svh"

// one leaf record travelling from the dispatcher to a single lane
interface header_req_if;
    import hh_pkg::*;

    logic                  load;       // one-cycle strobe, record is valid this cycle
    logic [`HH_CHAR_W-1:0] char_index; // character of the leaf that was found
    htree_elem_u           least1;     // first child of the element holding the leaf
    htree_elem_u           least2;     // second child of the element holding the leaf
    logic                  busy;       // lane holds a fragment that has not finished yet

    modport dispatcher (
        output load,
        output char_index,
        output least1,
        output least2,
        input  busy
    );

    modport lane (
        input  load,
        input  char_index,
        input  least1,
        input  least2,
        output busy
    );
endinterface

// ==== hdl/fragment_bit_if.sv ====
// serial handshake between one lane and the in-order collector
interface fragment_bit_if;

    logic grant;        // collector lets this lane shift, held until write_finish
    logic enable;       // lane has a valid bit on bit1 this cycle
    logic bit1;         // current fragment bit
    logic write_finish; // one-cycle pulse, comes the cycle after the last bit

    // lane side shifts its fragment out once granted
    modport lane (
        input  grant,
        output enable,
        output bit1,
        output write_finish
    );

    // collector side picks one lane at a time
    modport collector (
        output grant,
        input  enable,
        input  bit1,
        input  write_finish
    );

    // the lane never raises enable without grant, checked in the collector
endinterface

// ==== hdl/leaf_dispatcher.sv ====
`include "hh_defs.svh"

module leaf_dispatcher (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  found,      // codebook walker reached a leaf
    input  logic [`HH_CHAR_W-1:0] char_index, // character of that leaf
    input  hh_pkg::htree_elem_u   least1,     // first child of the element
    input  hh_pkg::htree_elem_u   least2,     // second child of the element
    output logic                  full,       // lane at the pointer is still busy
    header_req_if.dispatcher      req [`HH_LANES]
);
    import hh_pkg::*;

    lane_idx_t            ptr;      // lane that takes the next leaf
    logic [`HH_LANES-1:0] busy_vec; // busy levels gathered from all lanes
    logic                 accept;   // found and the target lane is free

    assign full   = busy_vec[ptr]; // combinational, follows the lane at the pointer
    assign accept = found && !full; // a strobe during full is dropped and flagged below

    // record fans out to every lane, only the lane at the pointer sees load
    for (genvar i = 0; i < `HH_LANES; i++) begin : g_route
        assign req[i].load       = accept && (ptr == lane_idx_t'(i)); // same cycle as found
        assign req[i].char_index = char_index;
        assign req[i].least1     = least1;
        assign req[i].least2     = least2;
        assign busy_vec[i]       = req[i].busy; // modport array needs a constant index
    end

    // round-robin pointer moves on after every accepted leaf
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ptr <= '0; // first leaf after reset goes to lane 0
        end else if (accept) begin
            if (ptr == lane_idx_t'(`HH_LANES - 1)) begin
                ptr <= '0; // wrap back to the first lane
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // the walker must hold off while the next lane in order has not drained
    a_no_found_when_full: assert property (
        @(posedge clk) disable iff (rst)
        full |-> !found
    ) else $error("found strobed while full is high");

endmodule

// ==== hdl/header_synthesis.sv ====
`include "hh_defs.svh"

module header_synthesis (
    input logic clk,
    input logic rst,
    header_req_if.lane    req,  // leaf record from the dispatcher
    fragment_bit_if.lane  frag  // serial bits toward the collector
);
    import hh_pkg::*;

    localparam int MSB = `HH_LEAD_BITS - 1; // top bit of the header shift register

    logic [`HH_LEAD_BITS-1:0] header;       // leading 1 above the character, shifted out msb first
    htree_elem_u              least1_q;     // first child kept for the zero decision
    htree_elem_u              least2_q;     // second child kept for the zero decision
    logic                     char_added;   // high the cycle after load, zeros get decided then
    logic                     ready;        // zeros known, waiting for grant
    zero_cnt_t                zeroes;       // trailing zeros of this fragment
    logic [3:0]               count;        // bits sent so far in this fragment
    logic                     enable;       // a bit is on bit1 this cycle
    logic                     bit1;         // current serial bit
    logic                     write_finish; // pulse after the last bit
    logic                     busy;         // lane owns a fragment
    logic                     start;        // first bit goes out on this edge
    logic                     shift_lead;   // a header bit is taken on this edge
    logic [3:0]               frag_len;     // lead bits plus trailing zeros

    assign frag_len   = 4'(`HH_LEAD_BITS) + 4'(zeroes);
    assign start      = ready && frag.grant && !enable; // collector points here and lane is idle
    assign shift_lead = start || (enable && (count < 4'(`HH_LEAD_BITS)));

    // record and header, shifted left as each lead bit leaves
    always_ff @(posedge clk) begin
        if (req.load) begin
            header   <= {1'b1, req.char_index}; // control 1 then the character
            least1_q <= req.least1;
            least2_q <= req.least2;
        end else if (shift_lead) begin
            header <= {header[MSB-1:0], 1'b0};
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            char_added   <= 1'b0;
            ready        <= 1'b0;
            zeroes       <= '0;
            count        <= '0;
            enable       <= 1'b0;
            bit1         <= 1'b0;
            write_finish <= 1'b0;
            busy         <= 1'b0;
        end else begin
            char_added   <= req.load;
            write_finish <= 1'b0; // pulse by default
            if (req.load) begin
                busy <= 1'b1; // visible to the dispatcher one cycle after load
            end else if (write_finish) begin
                busy <= 1'b0; // free again the cycle after the finish pulse
            end
            if (char_added) begin
                // both children are characters and ours is least2, so the element is complete
                if (!least1_q.leaf.is_sum && !least2_q.leaf.is_sum &&
                    (header[`HH_CHAR_W-1:0] == least2_q.leaf.char_index)) begin
                    zeroes <= zero_cnt_t'(2);
                end else if (least1_q.sum.is_sum != least2_q.sum.is_sum) begin
                    zeroes <= zero_cnt_t'(1); // exactly one child is a sum
                end else begin
                    zeroes <= '0; // both sums, or the right character is still to come
                end
                ready <= 1'b1;
            end
            if (start) begin
                enable <= 1'b1;
                bit1   <= header[MSB]; // leading 1 goes first
                count  <= 4'd1;
            end else if (enable) begin
                if (count < frag_len) begin
                    bit1  <= shift_lead ? header[MSB] : 1'b0; // character bits, then zeros
                    count <= count + 1'b1;
                end else begin
                    enable       <= 1'b0;
                    bit1         <= 1'b0;
                    count        <= '0;
                    ready        <= 1'b0;
                    write_finish <= 1'b1;
                end
            end
        end
    end

    assign req.busy          = busy;
    assign frag.enable       = enable;
    assign frag.bit1         = bit1;
    assign frag.write_finish = write_finish;

    // the dispatcher only loads a lane that has drained
    a_no_load_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        req.load |-> !busy
    ) else $error("lane loaded while busy");

    // a fragment never runs past the lead bits plus two zeros
    a_enable_bounded: assert property (
        @(posedge clk) disable iff (rst)
        $rose(enable) |-> ##[1:(`HH_LEAD_BITS + 2)] !enable
    ) else $error("enable held longer than a full fragment");

endmodule

// ==== hdl/fragment_collector.sv ====
`include "hh_defs.svh"

module fragment_collector (
    input  logic             clk,
    input  logic             rst,
    fragment_bit_if.collector frag [`HH_LANES], // one handshake per lane
    output logic             bit_valid,          // registered enable of the granted lane
    output logic             bit_data,           // registered bit of the granted lane
    output logic             frag_done           // registered write_finish of the granted lane
);
    import hh_pkg::*;

    lane_idx_t            ptr;     // lane that owns the serial output, same order as the dispatcher
    logic                 live;    // grant stays off until the first cycle out of reset
    logic [`HH_LANES-1:0] en_vec;  // enable of every lane
    logic [`HH_LANES-1:0] bit_vec; // bit1 of every lane
    logic [`HH_LANES-1:0] wf_vec;  // write_finish of every lane

    for (genvar i = 0; i < `HH_LANES; i++) begin : g_lane
        assign frag[i].grant = live && (ptr == lane_idx_t'(i)); // one lane at a time
        assign en_vec[i]     = frag[i].enable;
        assign bit_vec[i]    = frag[i].bit1;
        assign wf_vec[i]     = frag[i].write_finish;

        // a lane only shifts while it holds grant, so its bits can never be lost
        a_enable_needs_grant: assert property (
            @(posedge clk) disable iff (rst)
            frag[i].enable |-> frag[i].grant
        ) else $error("lane %0d shifted without grant", i);
    end

    // pointer and serial control
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ptr       <= '0;
            live      <= 1'b0;
            bit_valid <= 1'b0;
            frag_done <= 1'b0;
        end else begin
            live      <= 1'b1;
            bit_valid <= en_vec[ptr];
            frag_done <= wf_vec[ptr]; // marks the end of each fragment
            if (wf_vec[ptr]) begin
                // grant drops here and moves to the next lane in order
                if (ptr == lane_idx_t'(`HH_LANES - 1)) begin
                    ptr <= '0;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end
        end
    end

    // data bit follows the granted lane one cycle late, qualified by bit_valid
    always_ff @(posedge clk) begin
        bit_data <= bit_vec[ptr];
    end

endmodule

// ==== hdl/huffman_header_top.sv ====
`include "hh_defs.svh"

module huffman_header_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  found,      // leaf strobe from the codebook walker
    input  logic [`HH_CHAR_W-1:0] char_index, // character of the leaf
    input  hh_pkg::htree_elem_u   least1,     // first child of the element, 9 bits
    input  hh_pkg::htree_elem_u   least2,     // second child of the element, 9 bits
    output logic                  full,       // walker must not strobe found while high
    output logic                  bit_valid,  // serial bit strobe for the SPI writer
    output logic                  bit_data,   // serial bit, fragments in found order
    output logic                  frag_done   // one pulse after each fragment
);

    header_req_if   req_bus  [`HH_LANES] (); // dispatcher to lane records
    fragment_bit_if frag_bus [`HH_LANES] (); // lane to collector bit streams

    // round-robin loader, combinational toward the lanes
    leaf_dispatcher u_dispatcher (
        .clk        (clk),
        .rst        (rst),
        .found      (found),
        .char_index (char_index),
        .least1     (least1),
        .least2     (least2),
        .full       (full),
        .req        (req_bus)
    );

    // one header writer per lane, each holds one fragment
    for (genvar i = 0; i < `HH_LANES; i++) begin : g_lanes
        header_synthesis u_lane (
            .clk  (clk),
            .rst  (rst),
            .req  (req_bus[i]),
            .frag (frag_bus[i])
        );
    end

    // drains the lanes in the order they were filled
    fragment_collector u_collector (
        .clk       (clk),
        .rst       (rst),
        .frag      (frag_bus),
        .bit_valid (bit_valid),
        .bit_data  (bit_data),
        .frag_done (frag_done)
    );

endmodule

// ==== bench/huffman_header_tb.sv ====
`include "hh_defs.svh"

module huffman_header_tb;
    import hh_pkg::*;

    localparam int NUM_TESTS   = 5;
    localparam int WATCHDOG    = NUM_TESTS * 16 * 20 * 100; // tests x leaves x cycles x period
    localparam int DRAIN_LIMIT = 400;                       // cycles allowed for the lanes to empty
    localparam int FRAG_W      = `HH_LEAD_BITS + `HH_MAX_ZEROS;

    typedef logic [FRAG_W-1:0] frag_bits_t; // the first bit of a fragment ends up highest

    typedef struct {
        frag_bits_t  bits;
        int          len;
        zero_cnt_t   zeros;
        htree_elem_u l1;
        htree_elem_u l2;
    } exp_rec_t;

    logic                  clk;
    logic                  rst;
    logic                  found;
    logic [`HH_CHAR_W-1:0] char_index;
    htree_elem_u           least1;
    htree_elem_u           least2;
    logic                  full;
    logic                  bit_valid;
    logic                  bit_data;
    logic                  frag_done;

    exp_rec_t   exp_q[$];         // expected fragments in found order
    exp_rec_t   rec;              // fragment popped by the monitor
    frag_bits_t got_bits;         // bits gathered since the last frag_done
    int         got_len;
    int         errors = 0;
    int         found_count = 0;  // found strobes accepted by the DUT
    int         done_count = 0;   // frag_done pulses seen
    int         tests_run = 0;
    int         tests_failed = 0;
    logic [31:0] lcg_state = 32'ha7b8_a86e;

    huffman_header_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .found      (found),
        .char_index (char_index),
        .least1     (least1),
        .least2     (least2),
        .full       (full),
        .bit_valid  (bit_valid),
        .bit_data   (bit_data),
        .frag_done  (frag_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // period of 100
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // classic 32-bit LCG step
        return lcg_state;
    endfunction

    function automatic htree_elem_u make_elem(input logic is_sum, input logic [7:0] idx);
        htree_elem_u e;
        e.leaf.is_sum     = is_sum; // is_sum sits in the top bit of both views
        e.leaf.char_index = idx;
        return e;
    endfunction

    // the number of sum children decides how many zeros close the fragment
    function automatic zero_cnt_t model_zeros(input logic [7:0] ch, input htree_elem_u l1,
                                              input htree_elem_u l2);
        int sums;
        sums = int'(l1.sum.is_sum) + int'(l2.sum.is_sum);
        if (sums == 1) begin
            return zero_cnt_t'(1); // one child is a sum
        end
        if (sums == 0 && l2.leaf.char_index == ch) begin
            return zero_cnt_t'(2); // both characters of the element have been found
        end
        return zero_cnt_t'(0);
    endfunction

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_fragment(input frag_bits_t got, input int glen, input frag_bits_t exp,
                                  input int elen, input htree_elem_u l1, input htree_elem_u l2);
        if (got !== exp || glen != elen) begin
            $display("CHECK FAILED at %0t: bit_data got %b/%0d expected %b/%0d, children %h %h",
                     $time, got, glen, exp, elen, l1, l2);
            errors++;
        end
    endtask

    task automatic check_zeros(input zero_cnt_t got, input zero_cnt_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: trailing zeros got %0d expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    // serial bits are gathered between frag_done pulses, half a cycle after the outputs change
    always @(negedge clk) begin
        if (!rst) begin
            if (bit_valid) begin
                got_bits = {got_bits[FRAG_W-2:0], bit_data}; // first bit of the fragment ends on top
                got_len++;
            end else if (!frag_done && got_len != 0) begin
                $display("bit_valid dropped at %0t after %0d bits with no frag_done",
                         $time, got_len);
                errors++;
            end
            if (frag_done) begin
                done_count++;
                if (exp_q.size() == 0) begin
                    $display("frag_done at %0t with no fragment outstanding", $time);
                    errors++;
                end else begin
                    rec = exp_q.pop_front();
                    check_fragment(got_bits, got_len, rec.bits, rec.len, rec.l1, rec.l2);
                    check_zeros(zero_cnt_t'(got_len - `HH_LEAD_BITS), rec.zeros);
                end
                got_bits = '0;
                got_len  = 0;
            end
        end
    end

    // waits out full at a falling edge and strobes found for one cycle
    task automatic send_leaf(input logic [7:0] ch, input htree_elem_u l1, input htree_elem_u l2);
        exp_rec_t r;
        while (full) @(negedge clk);
        found      = 1'b1;
        char_index = ch;
        least1     = l1;
        least2     = l2;
        r.zeros = model_zeros(ch, l1, l2);
        r.len   = `HH_LEAD_BITS + int'(r.zeros);
        r.bits  = frag_bits_t'({1'b1, ch}) << r.zeros; // lead 1 and character above the zeros
        r.l1    = l1;
        r.l2    = l2;
        exp_q.push_back(r);
        found_count++;
        @(negedge clk);
        found = 1'b0;
    endtask

    // every accepted leaf must come back as exactly one frag_done pulse
    task automatic drain_fragments();
        int waited;
        waited = 0;
        while (done_count < found_count && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        check_count("frag_done pulses", done_count, found_count);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors > errs_before) begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - errs_before);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic idle_after_reset();
        int e0;
        e0 = errors;
        repeat (20) begin
            @(negedge clk);
            check_level("full", full, 1'b0);
            check_level("bit_valid", bit_valid, 1'b0);
            check_level("frag_done", frag_done, 1'b0);
        end
        report_test("idle after reset", e0);
    endtask

    task automatic complete_element();
        int e0;
        e0 = errors;
        send_leaf(8'h5a, make_elem(1'b0, 8'h3c), make_elem(1'b0, 8'h5a)); // 11 bits expected
        drain_fragments();
        report_test("complete element", e0);
    endtask

    task automatic single_sum_child();
        int e0;
        e0 = errors;
        send_leaf(8'ha1, make_elem(1'b1, 8'h07), make_elem(1'b0, 8'ha1)); // sum first
        drain_fragments();
        send_leaf(8'h42, make_elem(1'b0, 8'h42), make_elem(1'b1, 8'h13)); // sum second
        drain_fragments();
        send_leaf(8'hff, make_elem(1'b1, 8'h01), make_elem(1'b1, 8'h02)); // both sums
        drain_fragments();
        send_leaf(8'h00, make_elem(1'b0, 8'h00), make_elem(1'b0, 8'h81)); // least2 differs
        drain_fragments();
        report_test("one sum child and no zero cases", e0);
    endtask

    task automatic burst_in_order();
        int e0;
        logic [31:0] r;
        e0 = errors;
        repeat (2 * `HH_LANES + 2) begin
            r = next_rand();
            send_leaf(r[23:16], make_elem(r[31], r[15:8]), make_elem(r[30], r[23:16]));
        end
        drain_fragments();
        report_test("burst in found order", e0);
    endtask

    task automatic long_random_stream();
        int e0;
        logic [31:0] r;
        logic [31:0] s;
        e0 = errors;
        repeat (64) begin
            r = next_rand();
            s = next_rand();
            // half the time least2 carries our character so complete elements show up
            send_leaf(r[23:16], make_elem(s[31], s[15:8]),
                      make_elem(s[30], s[29] ? r[23:16] : s[23:16]));
            if (s[28] && s[27]) begin
                @(negedge clk); // occasional idle cycle between leaves
            end
        end
        drain_fragments();
        report_test("long random stream", e0);
    endtask

    initial begin
        #(WATCHDOG);
        $display("watchdog ran out at %0t with %0d fragments outstanding", $time, exp_q.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        found      = 1'b0;
        char_index = '0;
        least1     = '0;
        least2     = '0;
        got_bits   = '0;
        got_len    = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0; // lanes and pointers leave reset here
        idle_after_reset();
        complete_element();
        single_sum_child();
        burst_in_order();
        long_random_stream();
        $display("tests %0d, failed %0d, errors %0d, fragments %0d of %0d",
                 tests_run, tests_failed, errors, done_count, found_count);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== huffman_header_top.f ====
+incdir+include
hdl/hh_pkg.sv
hdl/header_req_if.sv
hdl/fragment_bit_if.sv
hdl/leaf_dispatcher.sv
hdl/header_synthesis.sv
hdl/fragment_collector.sv
hdl/huffman_header_top.sv
bench/huffman_header_tb.sv
